/* design/decode_pkg.sv */
// Shared types and constants for the RV32I + Zicsr instruction decoder.
// Decoders, the top level and the testbench import this package by wildcard.
`default_nettype none

package decode_pkg;

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        R_OP   = 7'b0110011,
        I_OP   = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 values in instr[14:12] by instruction class
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL / SRA
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;

    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [2:0] F3_PRIV    = 3'b000; // ECALL / EBREAK / MRET
    localparam logic [2:0] F3_CSRRW   = 3'b001;
    localparam logic [2:0] F3_CSRRS   = 3'b010;
    localparam logic [2:0] F3_CSRRC   = 3'b011;
    localparam logic [2:0] F3_CSRRWI  = 3'b101;
    localparam logic [2:0] F3_CSRRSI  = 3'b110;
    localparam logic [2:0] F3_CSRRCI  = 3'b111;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SRL, SRA, AND, OR, XOR,
        SLT, SLTU, EQ, NE, LT, GE, LTU, GEU
    } alu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_src_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_CSR} wb_src_e;

    typedef enum logic [1:0] {WR_NONE, WR_BYTE, WR_HALF, WR_WORD} wr_mode_e;

    // Encoded like the CSR funct3 values
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,
        CSR_RW   = 3'b001,
        CSR_RS   = 3'b010,
        CSR_RC   = 3'b011,
        CSR_RWI  = 3'b101,
        CSR_RSI  = 3'b110,
        CSR_RCI  = 3'b111
    } csr_op_e;

    typedef struct packed {
        a_src_e  a_src;
        logic    b_imm;  // Second operand is the immediate
        alu_op_e op;
    } alu_ctrl_t;

    typedef struct packed {
        logic     rf_we;
        wb_src_e  wb_src;
        wr_mode_e wr_mode;
        logic     branch;
        logic     jump;
    } flow_ctrl_t;

    typedef struct packed {
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic        csr_r_en;
        logic        csr_w_en;
        logic        csr_imm;   // Operand is the 5-bit uimm
        csr_op_e     csr_op;
        logic [11:0] csr_addr;
    } sys_ctrl_t;

    typedef struct packed {
        alu_ctrl_t  alu;
        flow_ctrl_t flow;
        sys_ctrl_t  sys;
    } ctrl_t;

    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MEPC  = 12'h341;

    localparam ctrl_t CTRL_NOP = '{
        alu:  '{a_src: A_RS1, b_imm: 1'b1, op: ADD},
        flow: '{rf_we: 1'b0, wb_src: WB_ALU, wr_mode: WR_NONE, branch: 1'b0, jump: 1'b0},
        sys:  '{ecall: 1'b0, ebreak: 1'b0, mret: 1'b0, csr_r_en: 1'b0, csr_w_en: 1'b0,
                csr_imm: 1'b0, csr_op: CSR_NONE, csr_addr: 12'h000}
    };

endpackage

`default_nettype wire

/* design/alu_decoder.sv */
// ALU operand source and operation decode.
// Purely combinational; drives the ALU part of the control bundle.
`default_nettype none

module alu_decoder
    import decode_pkg::*;
(
    input  logic [31:0] instr,
    output alu_ctrl_t   alu
);

    opcode_e    opcode;
    logic [2:0] funct3;
    alu_op_e    arith_op;
    alu_op_e    branch_op;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Shared R/I table
    always_comb
    begin
        case (funct3)
            F3_ADD_SUB:
            begin
                if (instr[30] && opcode == R_OP) // SUB only exists as R-type
                    arith_op = SUB;
                else
                    arith_op = ADD;
            end
            F3_SLL:  arith_op = SLL;
            F3_SLT:  arith_op = SLT;
            F3_SLTU: arith_op = SLTU;
            F3_XOR:  arith_op = XOR;
            F3_SR:
            begin
                if (instr[30])
                    arith_op = SRA;
                else
                    arith_op = SRL;
            end
            F3_OR:   arith_op = OR;
            F3_AND:  arith_op = AND;
            default: arith_op = ADD;
        endcase
    end

    always_comb
    begin
        case (funct3)
            F3_BEQ:  branch_op = EQ;
            F3_BNE:  branch_op = NE;
            F3_BLT:  branch_op = LT;
            F3_BGE:  branch_op = GE;
            F3_BLTU: branch_op = LTU;
            F3_BGEU: branch_op = GEU;
            default: branch_op = EQ; // Reserved encodings keep the branch flag low
        endcase
    end

    always_comb
    begin
        alu = CTRL_NOP.alu;
        case (opcode)
            R_OP:
            begin
                alu.b_imm = 1'b0;
                alu.op    = arith_op;
            end
            I_OP:
            begin
                alu.op = arith_op;
            end
            BRANCH:
            begin
                alu.a_src = A_PC;
                alu.op    = branch_op;
            end
            JAL, AUIPC:
            begin
                alu.a_src = A_PC;
            end
            LUI:
            begin
                alu.a_src = A_ZERO; // 0 + U-immediate
            end
            default: ;
        endcase
    end

    // Branch unit relies on a compare code for every branch word
    always_comb
    begin
        if (opcode == BRANCH)
            assert #0 (alu.op inside {EQ, NE, LT, GE, LTU, GEU})
            else $error("branch decoded to non-compare op %0h", alu.op);
    end

endmodule

`default_nettype wire

/* design/flow_decoder.sv */
// Writeback, store width and control-flow decode.
// Purely combinational; drives the flow part of the control bundle.
`default_nettype none

module flow_decoder
    import decode_pkg::*;
(
    input  logic [31:0] instr,
    output flow_ctrl_t  flow
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       rd_zero;

    assign opcode  = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rd_zero = (instr[11:7] == 5'd0);

    always_comb
    begin
        flow = CTRL_NOP.flow;
        case (opcode)
            R_OP, I_OP, LUI, AUIPC:
            begin
                flow.rf_we = 1'b1;
            end
            LOAD:
            begin
                case (funct3)
                    F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU:
                    begin
                        flow.rf_we  = 1'b1;
                        flow.wb_src = WB_MEM;
                    end
                    default: ;
                endcase
            end
            STORE:
            begin
                case (funct3)
                    F3_SB:   flow.wr_mode = WR_BYTE;
                    F3_SH:   flow.wr_mode = WR_HALF;
                    F3_SW:   flow.wr_mode = WR_WORD;
                    default: ;
                endcase
            end
            BRANCH:
            begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: flow.branch = 1'b1;
                    default: ;
                endcase
            end
            JAL, JALR:
            begin
                flow.rf_we  = 1'b1;
                flow.wb_src = WB_LINK; // Return address
                flow.jump   = 1'b1;
            end
            SYSTEM:
            begin
                case (funct3)
                    F3_CSRRW, F3_CSRRWI:
                    begin
                        flow.rf_we  = !rd_zero;
                        flow.wb_src = WB_CSR;
                    end
                    F3_CSRRS, F3_CSRRC, F3_CSRRSI, F3_CSRRCI:
                    begin
                        flow.rf_we  = 1'b1;
                        flow.wb_src = WB_CSR;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // PC mux in the fetch stage takes one redirect source at a time
    always_comb
    begin
        assert #0 (!(flow.branch && flow.jump))
        else $error("branch and jump decoded together");
    end

endmodule

`default_nettype wire

/* design/system_decoder.sv */
// CSR access and trap instruction decode.
// Purely combinational; drives the system part of the control bundle.
`default_nettype none

module system_decoder
    import decode_pkg::*;
(
    input  logic [31:0] instr,
    output sys_ctrl_t   sys
);

    logic       is_system;
    logic [2:0] funct3;
    logic       rd_zero;
    logic       rs1_zero;
    logic       csr_form;

    assign is_system = (instr[6:0] == SYSTEM);
    assign funct3    = instr[14:12];
    assign rd_zero   = (instr[11:7] == 5'd0);
    assign rs1_zero  = (instr[19:15] == 5'd0); // rs1 or uimm
    assign csr_form  = (funct3[1:0] != 2'b00);  // Excludes PRIV and reserved 100

    always_comb
    begin
        sys = CTRL_NOP.sys;
        if (is_system)
        begin
            if (csr_form)
            begin
                sys.csr_op   = csr_op_e'(funct3);
                sys.csr_addr = instr[31:20];
                sys.csr_imm  = funct3[2];
            end
            case (funct3)
                F3_PRIV:
                begin
                    sys.csr_r_en = 1'b1;
                    case (instr[31:20])
                        12'h000:
                        begin
                            sys.ecall    = 1'b1;
                            sys.csr_addr = CSR_MTVEC;
                        end
                        12'h001:
                        begin
                            sys.ebreak   = 1'b1;
                            sys.csr_addr = CSR_MTVEC;
                        end
                        12'h302:
                        begin
                            sys.mret     = 1'b1;
                            sys.csr_addr = CSR_MEPC; // Return target
                        end
                        default: ;
                    endcase
                end
                F3_CSRRW, F3_CSRRWI:
                begin
                    sys.csr_w_en = 1'b1;
                    sys.csr_r_en = !rd_zero; // No read side effects for rd = x0
                end
                F3_CSRRS, F3_CSRRC, F3_CSRRSI, F3_CSRRCI:
                begin
                    sys.csr_r_en = 1'b1;
                    sys.csr_w_en = !rs1_zero;
                end
                default: ;
            endcase
        end
    end

    always_comb
    begin
        assert #0 (!sys.csr_w_en || sys.csr_op != CSR_NONE)
        else $error("CSR write without CSR operation");
    end

endmodule

`default_nettype wire

/* design/control_unit.sv */
// Decode stage top level. Decodes one instruction per instr_valid strobe
// and presents the registered control bundle one cycle later with ctrl_valid.
`default_nettype none

module control_unit
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        ctrl_valid,
    output ctrl_t       ctrl
);

    alu_ctrl_t  alu;
    flow_ctrl_t flow;
    sys_ctrl_t  sys;

    alu_decoder u_alu_dec
    (
        .instr (instr),
        .alu   (alu)
    );

    flow_decoder u_flow_dec
    (
        .instr (instr),
        .flow  (flow)
    );

    system_decoder u_sys_dec
    (
        .instr (instr),
        .sys   (sys)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_valid <= 1'b0;
            ctrl       <= CTRL_NOP;
        end
        else
        begin
            ctrl_valid <= instr_valid;
            if (instr_valid)
                ctrl <= '{alu: alu, flow: flow, sys: sys}; // Holds otherwise
        end
    end

    // One result per accepted instruction in the next cycle
    assert property (@(posedge clk) disable iff (rst) ctrl_valid |-> $past(instr_valid))
    else $error("ctrl_valid without instruction in previous cycle");

endmodule

`default_nettype wire

/* dv/control_unit_tb.sv */
// Testbench for the decode stage. Random instruction words from an LFSR are
// checked one cycle after acceptance against a decode model kept here.
// The run stops at the first mismatch or when the cycle limit is hit.
`default_nettype none

module control_unit_tb
    import decode_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 100;
    localparam int DRIVE_DELAY    = 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        ctrl_valid;
    ctrl_t       ctrl;

    logic [31:0] lfsr;
    int          cycle_count = 0;
    ctrl_t       pending_ctrl[$];   // One entry at most
    logic [31:0] pending_instr[$];
    ctrl_t       exp_ctrl;
    logic        exp_valid;
    logic [31:0] exp_instr;
    int          ecall_hits = 0;
    int          ebreak_hits = 0;
    int          mret_hits = 0;
    int          csr_write_hits = 0;
    int          csr_read_only_hits = 0;
    int          csr_no_read_hits = 0;

    control_unit u_dut
    (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_run("Timeout: the test sequence did not finish within the cycle limit");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [6:0] opcode_at(input logic [31:0] idx);
        case (idx)
            0:       return R_OP;
            1:       return I_OP;
            2:       return LOAD;
            3:       return STORE;
            4:       return BRANCH;
            5:       return JAL;
            6:       return JALR;
            7:       return LUI;
            8:       return AUIPC;
            9:       return FENCE;
            default: return SYSTEM;
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        logic [31:0] sel;
        if (rand_bits(4) == 32'd0)
            return rand_bits(32); // Mostly unknown opcodes
        word      = rand_bits(32);
        word[6:0] = opcode_at(rand_bits(4) % 11);
        sel       = rand_bits(3);
        case (sel)
            0:       word[11:7]  = 5'd0;
            1:       word[19:15] = 5'd0;
            2:       word[31:20] = 12'h000;
            3:       word[31:20] = 12'h001;
            4:       word[31:20] = 12'h302;
            default: ;
        endcase
        if (word[6:0] == SYSTEM && rand_bits(2) == 32'd0)
            word[14:12] = 3'b000; // More trap words
        return word;
    endfunction

    function automatic ctrl_t expected_ctrl(input logic [31:0] ins);
        ctrl_t      c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       rd_nz;
        logic       rs1_nz;
        c      = CTRL_NOP;
        opc    = ins[6:0];
        f3     = ins[14:12];
        rd_nz  = (ins[11:7] != 5'd0);
        rs1_nz = (ins[19:15] != 5'd0);
        case (opc)
            R_OP, I_OP:
            begin
                c.alu.b_imm  = (opc == I_OP);
                c.flow.rf_we = 1'b1;
                case (f3)
                    3'b000:
                    begin
                        if (opc == R_OP && ins[30])
                            c.alu.op = SUB;
                        else
                            c.alu.op = ADD;
                    end
                    3'b001:  c.alu.op = SLL;
                    3'b010:  c.alu.op = SLT;
                    3'b011:  c.alu.op = SLTU;
                    3'b100:  c.alu.op = XOR;
                    3'b101:
                    begin
                        if (ins[30])
                            c.alu.op = SRA;
                        else
                            c.alu.op = SRL;
                    end
                    3'b110:  c.alu.op = OR;
                    default: c.alu.op = AND;
                endcase
            end
            LOAD:
            begin
                if (f3 != 3'b011 && f3 < 3'b110)
                begin
                    c.flow.rf_we  = 1'b1;
                    c.flow.wb_src = WB_MEM;
                end
            end
            STORE:
            begin
                case (f3)
                    3'b000:  c.flow.wr_mode = WR_BYTE;
                    3'b001:  c.flow.wr_mode = WR_HALF;
                    3'b010:  c.flow.wr_mode = WR_WORD;
                    default: ;
                endcase
            end
            BRANCH:
            begin
                c.alu.a_src   = A_PC;
                c.flow.branch = (f3 != 3'b010 && f3 != 3'b011);
                case (f3)
                    3'b001:  c.alu.op = NE;
                    3'b100:  c.alu.op = LT;
                    3'b101:  c.alu.op = GE;
                    3'b110:  c.alu.op = LTU;
                    3'b111:  c.alu.op = GEU;
                    default: c.alu.op = EQ;
                endcase
            end
            JAL, JALR:
            begin
                if (opc == JAL)
                    c.alu.a_src = A_PC;
                c.flow.rf_we  = 1'b1;
                c.flow.wb_src = WB_LINK;
                c.flow.jump   = 1'b1;
            end
            LUI, AUIPC:
            begin
                if (opc == LUI)
                    c.alu.a_src = A_ZERO;
                else
                    c.alu.a_src = A_PC;
                c.flow.rf_we = 1'b1;
            end
            SYSTEM:
            begin
                if (f3 == 3'b000)
                begin
                    c.sys.csr_r_en = 1'b1;
                    c.sys.ecall    = (ins[31:20] == 12'h000);
                    c.sys.ebreak   = (ins[31:20] == 12'h001);
                    c.sys.mret     = (ins[31:20] == 12'h302);
                    if (c.sys.ecall || c.sys.ebreak)
                        c.sys.csr_addr = CSR_MTVEC;
                    if (c.sys.mret)
                        c.sys.csr_addr = CSR_MEPC;
                end
                else if (f3 != 3'b100)
                begin
                    c.sys.csr_addr = ins[31:20];
                    c.sys.csr_imm  = (f3 inside {3'b101, 3'b110, 3'b111});
                    c.flow.wb_src  = WB_CSR;
                    case (f3)
                        3'b001:  c.sys.csr_op = CSR_RW;
                        3'b010:  c.sys.csr_op = CSR_RS;
                        3'b011:  c.sys.csr_op = CSR_RC;
                        3'b101:  c.sys.csr_op = CSR_RWI;
                        3'b110:  c.sys.csr_op = CSR_RSI;
                        default: c.sys.csr_op = CSR_RCI;
                    endcase
                    if (f3[1:0] == 2'b01)
                    begin
                        c.sys.csr_w_en = 1'b1;
                        c.sys.csr_r_en = rd_nz;
                        c.flow.rf_we   = rd_nz;
                    end
                    else
                    begin
                        c.sys.csr_r_en = 1'b1;
                        c.sys.csr_w_en = rs1_nz;
                        c.flow.rf_we   = 1'b1;
                    end
                end
            end
            default: ;
        endcase
        return c;
    endfunction

    task automatic check_ctrl(input ctrl_t actual, input ctrl_t expected);
        if (actual.alu !== expected.alu)
            fail_run($sformatf("CHECK FAILED ctrl.alu: got %h, expected %h (instr %h)",
                               actual.alu, expected.alu, exp_instr));
        if (actual.flow !== expected.flow)
            fail_run($sformatf("CHECK FAILED ctrl.flow: got %h, expected %h (instr %h)",
                               actual.flow, expected.flow, exp_instr));
        if (actual.sys !== expected.sys)
            fail_run($sformatf("CHECK FAILED ctrl.sys: got %h, expected %h (instr %h)",
                               actual.sys, expected.sys, exp_instr));
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED ctrl_valid: got %h, expected %h",
                               actual, expected));
    endtask

    // Checks the result of the previous cycle's instruction
    task automatic check_outputs();
        exp_valid = (pending_ctrl.size() != 0);
        if (exp_valid)
        begin
            exp_ctrl  = pending_ctrl.pop_front();
            exp_instr = pending_instr.pop_front();
        end
        check_valid(ctrl_valid, exp_valid);
        check_ctrl(ctrl, exp_ctrl);
    endtask

    task automatic count_cases(input ctrl_t c);
        if (c.sys.ecall)
            ecall_hits++;
        if (c.sys.ebreak)
            ebreak_hits++;
        if (c.sys.mret)
            mret_hits++;
        if (c.sys.csr_w_en)
            csr_write_hits++;
        if (c.sys.csr_op != CSR_NONE && !c.sys.csr_w_en)
            csr_read_only_hits++;
        if (c.sys.csr_op != CSR_NONE && !c.sys.csr_r_en)
            csr_no_read_hits++;
    endtask

    initial
    begin
        rst         = 1'b1;
        lfsr        = 32'hd9e1;
        instr_valid = 1'b1;          // Reset must win over a pending load
        instr       = 32'h3051_10f3; // csrrw x1, mtvec, x2
        exp_ctrl    = CTRL_NOP;
        exp_instr   = 32'h0000_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst         = 1'b0;
        instr_valid = 1'b0;
        check_outputs(); // Reset values
        for (int i = 0; i < NUM_CYCLES; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_outputs();
            instr_valid = (rand_bits(2) != 32'd0);
            instr       = random_instr();
            if (instr_valid)
            begin
                pending_ctrl.push_back(expected_ctrl(instr));
                pending_instr.push_back(instr);
                count_cases(expected_ctrl(instr));
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_outputs();
        instr_valid = 1'b0;
        if (ecall_hits == 0 || ebreak_hits == 0 || mret_hits == 0 || csr_write_hits == 0 ||
            csr_read_only_hits == 0 || csr_no_read_hits == 0)
            fail_run("Not every trap and CSR case was exercised by the random stimulus");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
design/decode_pkg.sv
design/alu_decoder.sv
design/flow_decoder.sv
design/system_decoder.sv
design/control_unit.sv
dv/control_unit_tb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f tb.f --top-module control_unit_tb -Mdir $(BUILD) -o sim
	./$(BUILD)/sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
